// ==== Bender.yml ====
package:
  name: div_unit

sources:
  - logic/div_pkg.sv
  - logic/div_prepare.sv
  - logic/div_iterate.sv
  - logic/div_finish.sv
  - logic/div_unit.sv
  - target: test
    files:
      - verification/div_tb_clock.sv
      - verification/div_asserts.sv
      - verification/div_tb.sv

// ==== all.f ====
logic/div_pkg.sv
logic/div_prepare.sv
logic/div_iterate.sv
logic/div_finish.sv
logic/div_unit.sv
verification/div_tb_clock.sv
verification/div_asserts.sv
verification/div_tb.sv

// ==== logic/div_finish.sv ====
`timescale 1ns/10ps

module div_finish #(
  parameter int width = div_pkg::data_width_default
) (
  input  logic             clk,
  input  logic             rst,
  input  logic             i_done,
  input  logic [width-1:0] i_quotient,
  input  logic [width-1:0] i_remainder,
  input  logic             i_quot_neg,
  input  logic             i_rem_neg,
  input  logic             i_want_rem,
  input  logic             i_special,
  input  logic [width-1:0] i_special_value,
  output logic [width-1:0] result,
  output logic             ready
);

  logic [width-1:0] quotient_fix;
  logic [width-1:0] remainder_fix;
  logic [width-1:0] value;

  always_comb begin
    quotient_fix  = i_quot_neg ? -i_quotient : i_quotient;
    remainder_fix = i_rem_neg ? -i_remainder : i_remainder;
    if (i_special) begin
      value = i_special_value; // Divide by zero or signed overflow
    end else if (i_want_rem) begin
      value = remainder_fix;
    end else begin
      value = quotient_fix;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst) begin
      result <= '0;
      ready  <= 1'b0;
    end else begin
      ready <= i_done;
      if (i_done) begin
        result <= value; // Held until the next operation completes
      end
    end
  end

endmodule

// ==== logic/div_iterate.sv ====
`timescale 1ns/10ps

module div_iterate #(
  parameter int width = div_pkg::data_width_default
) (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       p_valid,
  input  logic [width-1:0]           p_dividend,
  input  logic [width-1:0]           p_divisor,
  input  logic [$clog2(width+1)-1:0] p_steps,
  input  logic                       p_quot_neg,
  input  logic                       p_rem_neg,
  input  logic                       p_want_rem,
  input  logic                       p_special,
  input  logic [width-1:0]           p_special_value,
  output logic                       i_done,
  output logic [width-1:0]           i_quotient,
  output logic [width-1:0]           i_remainder,
  output logic                       i_quot_neg,
  output logic                       i_rem_neg,
  output logic                       i_want_rem,
  output logic                       i_special,
  output logic [width-1:0]           i_special_value
);

  localparam int cnt_width = $clog2(width + 1);

  // Upper half holds the partial remainder, lower half the quotient
  logic [2*width-1:0]   acc;
  logic [2*width:0]     shifted; // Top bit is the guard bit of the shifted partial remainder
  logic [width:0]       diff;
  logic [width-1:0]     divisor;
  logic [cnt_width-1:0] count;
  logic                 running;

  always_comb begin
    shifted = {acc, 1'b0};
    diff    = shifted[2*width:width] - {1'b0, divisor};
  end

  always_ff @(posedge clk) begin
    if (!rst) begin
      running <= 1'b0;
      count   <= '0;
      i_done  <= 1'b0;
    end else begin
      i_done <= 1'b0;
      if (p_valid) begin
        running <= 1'b1;
        count   <= p_steps;
      end else if (running) begin
        if (count == '0) begin
          running <= 1'b0;
          i_done  <= 1'b1;
        end else begin
          count <= count - 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (p_valid) begin
      acc             <= {{width{1'b0}}, p_dividend};
      divisor         <= p_divisor;
      i_quot_neg      <= p_quot_neg;
      i_rem_neg       <= p_rem_neg;
      i_want_rem      <= p_want_rem;
      i_special       <= p_special;
      i_special_value <= p_special_value;
    end else if (running && (count != '0)) begin
      if (!diff[width]) begin
        acc <= {diff[width-1:0], shifted[width-1:1], 1'b1}; // Divisor fits so keep the difference
      end else begin
        acc <= shifted[2*width-1:0]; // Restore
      end
    end
  end

  assign i_quotient  = acc[width-1:0];
  assign i_remainder = acc[2*width-1:width];

endmodule

// ==== logic/div_pkg.sv ====
package div_pkg;

  // Width of the operation code
  localparam int op_width = 2;

  // RV32M divide and remainder selectors
  localparam logic [op_width-1:0] op_div  = 2'b00;
  localparam logic [op_width-1:0] op_divu = 2'b01;
  localparam logic [op_width-1:0] op_rem  = 2'b10;
  localparam logic [op_width-1:0] op_remu = 2'b11;

  localparam int data_width_default = 32; // Operand and result width used by the top level

endpackage

// ==== logic/div_prepare.sv ====
`timescale 1ns/10ps

module div_prepare #(
  parameter int width = div_pkg::data_width_default
) (
  input  logic                         clk,
  input  logic                         rst,
  input  logic                         enable,
  input  logic [div_pkg::op_width-1:0] op,
  input  logic [width-1:0]             rdata1,
  input  logic [width-1:0]             rdata2,
  input  logic                         busy_clear,
  output logic                         busy,
  output logic                         p_valid,
  output logic [width-1:0]             p_dividend,
  output logic [width-1:0]             p_divisor,
  output logic [$clog2(width+1)-1:0]   p_steps,
  output logic                         p_quot_neg,
  output logic                         p_rem_neg,
  output logic                         p_want_rem,
  output logic                         p_special,
  output logic [width-1:0]             p_special_value
);

  localparam int cnt_width = $clog2(width + 1);
  localparam logic [width-1:0] min_int = {1'b1, {(width-1){1'b0}}};
  localparam logic [cnt_width-1:0] full_steps = cnt_width'(width);

  logic                 busy_q;
  logic                 accept;
  logic                 is_signed;
  logic                 want_rem;
  logic                 a_neg;
  logic                 b_neg;
  logic [width-1:0]     abs_a;
  logic [width-1:0]     abs_b;
  logic [cnt_width-1:0] lz;
  logic                 found;
  logic                 div_zero;
  logic                 overflow;
  logic [width-1:0]     special_value;
  logic [cnt_width-1:0] steps;

  // A finishing operation frees the unit in the same cycle as its ready pulse
  assign busy   = busy_q & ~busy_clear;
  assign accept = enable & ~busy;

  always_comb begin
    is_signed = (op == div_pkg::op_div) || (op == div_pkg::op_rem);
    want_rem  = (op == div_pkg::op_rem) || (op == div_pkg::op_remu);
    a_neg     = is_signed & rdata1[width-1];
    b_neg     = is_signed & rdata2[width-1];
    abs_a     = a_neg ? -rdata1 : rdata1; // The most negative value maps onto its own magnitude
    abs_b     = b_neg ? -rdata2 : rdata2;
  end

  // Leading zeros of the magnitude are skipped by the iteration stage
  always_comb begin
    lz    = '0;
    found = 1'b0;
    for (int i = width - 1; i >= 0; i--) begin
      if (!found) begin
        if (abs_a[i]) begin
          found = 1'b1;
        end else begin
          lz = lz + 1'b1;
        end
      end
    end
  end

  always_comb begin
    div_zero = (rdata2 == '0);
    overflow = is_signed && (rdata1 == min_int) && (rdata2 == '1);
    if (div_zero) begin
      special_value = want_rem ? rdata1 : '1;
    end else begin
      special_value = want_rem ? '0 : min_int;
    end
    if (div_zero || overflow) begin
      steps = '0;
    end else begin
      steps = full_steps - lz; // Zero when the dividend is zero
    end
  end

  always_ff @(posedge clk) begin
    if (!rst) begin
      busy_q  <= 1'b0;
      p_valid <= 1'b0;
    end else begin
      p_valid <= accept;
      if (accept) begin
        busy_q <= 1'b1;
      end else if (busy_clear) begin
        busy_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      p_dividend      <= abs_a << lz;
      p_divisor       <= abs_b;
      p_steps         <= steps;
      p_quot_neg      <= a_neg ^ b_neg;
      p_rem_neg       <= a_neg; // Remainder follows the dividend sign
      p_want_rem      <= want_rem;
      p_special       <= div_zero | overflow;
      p_special_value <= special_value;
    end
  end

endmodule

// ==== logic/div_unit.sv ====
`timescale 1ns/10ps

module div_unit #(
  parameter int width = div_pkg::data_width_default
) (
  input  logic                         clk,
  input  logic                         rst,
  input  logic                         enable,
  input  logic [div_pkg::op_width-1:0] op,
  input  logic [width-1:0]             rdata1,
  input  logic [width-1:0]             rdata2,
  output logic [width-1:0]             result,
  output logic                         ready,
  output logic                         busy
);

  localparam int cnt_width = $clog2(width + 1);

  logic                 p_valid;
  logic [width-1:0]     p_dividend;
  logic [width-1:0]     p_divisor;
  logic [cnt_width-1:0] p_steps;
  logic                 p_quot_neg;
  logic                 p_rem_neg;
  logic                 p_want_rem;
  logic                 p_special;
  logic [width-1:0]     p_special_value;

  logic                 i_done;
  logic [width-1:0]     i_quotient;
  logic [width-1:0]     i_remainder;
  logic                 i_quot_neg;
  logic                 i_rem_neg;
  logic                 i_want_rem;
  logic                 i_special;
  logic [width-1:0]     i_special_value;

  div_prepare #(
    .width(width)
  ) i_prepare (
    .clk            (clk),
    .rst            (rst),
    .enable         (enable),
    .op             (op),
    .rdata1         (rdata1),
    .rdata2         (rdata2),
    .busy_clear     (ready), // Completion frees the unit for the next start
    .busy           (busy),
    .p_valid        (p_valid),
    .p_dividend     (p_dividend),
    .p_divisor      (p_divisor),
    .p_steps        (p_steps),
    .p_quot_neg     (p_quot_neg),
    .p_rem_neg      (p_rem_neg),
    .p_want_rem     (p_want_rem),
    .p_special      (p_special),
    .p_special_value(p_special_value)
  );

  div_iterate #(
    .width(width)
  ) i_iterate (
    .clk            (clk),
    .rst            (rst),
    .p_valid        (p_valid),
    .p_dividend     (p_dividend),
    .p_divisor      (p_divisor),
    .p_steps        (p_steps),
    .p_quot_neg     (p_quot_neg),
    .p_rem_neg      (p_rem_neg),
    .p_want_rem     (p_want_rem),
    .p_special      (p_special),
    .p_special_value(p_special_value),
    .i_done         (i_done),
    .i_quotient     (i_quotient),
    .i_remainder    (i_remainder),
    .i_quot_neg     (i_quot_neg),
    .i_rem_neg      (i_rem_neg),
    .i_want_rem     (i_want_rem),
    .i_special      (i_special),
    .i_special_value(i_special_value)
  );

  div_finish #(
    .width(width)
  ) i_finish (
    .clk            (clk),
    .rst            (rst),
    .i_done         (i_done),
    .i_quotient     (i_quotient),
    .i_remainder    (i_remainder),
    .i_quot_neg     (i_quot_neg),
    .i_rem_neg      (i_rem_neg),
    .i_want_rem     (i_want_rem),
    .i_special      (i_special),
    .i_special_value(i_special_value),
    .result         (result),
    .ready          (ready)
  );

endmodule

// ==== verification/div_asserts.sv ====
`timescale 1ns/10ps

module div_asserts (
  input logic clk,
  input logic rst,
  input logic ready,
  input logic busy
);

  // Completion is a single cycle pulse
  property ready_single_cycle;
    @(posedge clk) disable iff (!rst) ready |=> !ready;
  endproperty

  // Reset leaves the unit idle
  property idle_after_reset;
    @(posedge clk) !rst |=> !busy;
  endproperty

  // The unit was working in the cycle before it completes
  property ready_after_busy;
    @(posedge clk) disable iff (!rst) ready |-> $past(busy);
  endproperty

  a_ready_single_cycle : assert property (ready_single_cycle)
    else $error("ready stayed high for two cycles in a row");

  a_idle_after_reset : assert property (idle_after_reset)
    else $error("busy is high right after reset");

  a_ready_after_busy : assert property (ready_after_busy)
    else $error("ready rose without busy high in the cycle before");

endmodule

// ==== verification/div_tb.sv ====
`timescale 1ns/10ps

module div_tb;

  localparam int width         = div_pkg::data_width_default;
  localparam int n_table       = 28;
  localparam int n_random      = 40;
  localparam int n_tests       = n_table + n_random + 1;
  localparam int timeout_limit = n_tests * (width + 8) + 50;
  localparam logic [width-1:0] min_int = {1'b1, {(width-1){1'b0}}};

  logic                         clk;
  logic                         rst;
  logic                         enable;
  logic [div_pkg::op_width-1:0] op;
  logic [width-1:0]             rdata1;
  logic [width-1:0]             rdata2;
  logic [width-1:0]             result;
  logic                         ready;
  logic                         busy;

  logic [div_pkg::op_width-1:0] tab_op [n_table];
  logic [width-1:0]             tab_a [n_table];
  logic [width-1:0]             tab_b [n_table];
  logic [width-1:0]             tab_exp [n_table];
  logic                         tab_poke [n_table]; // Give a second enable while busy
  int                           tab_count = 0;

  logic [15:0] lfsr_state;
  int          errors = 0;
  int          tests_run = 0;
  int          cycle_count = 0;

  div_tb_clock i_clock (
    .clk(clk),
    .rst(rst)
  );

  div_unit #(
    .width(width)
  ) i_div_unit (
    .clk   (clk),
    .rst   (rst),
    .enable(enable),
    .op    (op),
    .rdata1(rdata1),
    .rdata2(rdata2),
    .result(result),
    .ready (ready),
    .busy  (busy)
  );

  bind div_unit div_asserts i_asserts (
    .clk  (clk),
    .rst  (rst),
    .ready(ready),
    .busy (busy)
  );

  // Galois LFSR x^16 + x^14 + x^13 + x^11 + 1, one step per bit
  function automatic logic take_bit();
    logic out;
    out = lfsr_state[0];
    lfsr_state = lfsr_state >> 1;
    if (out) begin
      lfsr_state = lfsr_state ^ 16'hB400;
    end
    return out;
  endfunction

  function automatic logic [width-1:0] to_word(input int value);
    return value; // Sign extends small negative numbers
  endfunction

  function automatic logic [width-1:0] model_result(input logic [1:0] m_op,
                                                    input logic [width-1:0] a,
                                                    input logic [width-1:0] b);
    logic signed [width-1:0] sa;
    logic signed [width-1:0] sb;
    logic                    is_signed;
    logic                    want_rem;
    logic [width-1:0]        res;
    sa        = a;
    sb        = b;
    is_signed = (m_op == div_pkg::op_div) || (m_op == div_pkg::op_rem);
    want_rem  = (m_op == div_pkg::op_rem) || (m_op == div_pkg::op_remu);
    if (b == '0) begin
      res = want_rem ? a : '1;
    end else if (is_signed && (a == min_int) && (b == '1)) begin
      res = want_rem ? '0 : min_int;
    end else if (is_signed) begin
      res = want_rem ? sa % sb : sa / sb; // Truncates toward zero
    end else begin
      res = want_rem ? a % b : a / b;
    end
    return res;
  endfunction

  // Steps are the significant bits of the dividend magnitude, plus three stages
  function automatic int expected_latency(input logic [1:0] m_op,
                                          input logic [width-1:0] a,
                                          input logic [width-1:0] b);
    logic             is_signed;
    logic [width-1:0] mag;
    int               steps;
    is_signed = (m_op == div_pkg::op_div) || (m_op == div_pkg::op_rem);
    mag       = (is_signed && a[width-1]) ? -a : a;
    steps     = 0;
    for (int k = 0; k < width; k++) begin
      if (mag[k]) begin
        steps = k + 1;
      end
    end
    if ((b == '0) || (is_signed && (a == min_int) && (b == '1))) begin
      steps = 0;
    end
    return steps + 3;
  endfunction

  task automatic check(input string name, input logic [63:0] got, input logic [63:0] expected);
    if (got !== expected) begin
      $display("MISMATCH %s got %h expected %h", name, got, expected);
      errors++;
    end
  endtask

  task automatic add_vector(input logic [1:0] v_op, input logic [width-1:0] a,
                            input logic [width-1:0] b, input logic [width-1:0] expected,
                            input logic poke);
    tab_op[tab_count]   = v_op;
    tab_a[tab_count]    = a;
    tab_b[tab_count]    = b;
    tab_exp[tab_count]  = expected;
    tab_poke[tab_count] = poke;
    tab_count++;
  endtask

  task automatic load_table();
    add_vector(div_pkg::op_divu, to_word(100), to_word(7), to_word(14), 1'b0);
    add_vector(div_pkg::op_remu, to_word(100), to_word(7), to_word(2), 1'b0);
    add_vector(div_pkg::op_divu, '0, to_word(5), '0, 1'b0);
    add_vector(div_pkg::op_remu, '0, to_word(5), '0, 1'b0);
    add_vector(div_pkg::op_divu, '1, to_word(1), '1, 1'b0);
    add_vector(div_pkg::op_remu, '1, to_word(2), to_word(1), 1'b0);
    add_vector(div_pkg::op_divu, '1, '1, to_word(1), 1'b1);
    add_vector(div_pkg::op_div, to_word(7), to_word(-2), to_word(-3), 1'b0);
    add_vector(div_pkg::op_rem, to_word(7), to_word(-2), to_word(1), 1'b0);
    add_vector(div_pkg::op_div, to_word(-7), to_word(2), to_word(-3), 1'b0);
    add_vector(div_pkg::op_rem, to_word(-7), to_word(2), to_word(-1), 1'b0);
    add_vector(div_pkg::op_div, to_word(-7), to_word(-2), to_word(3), 1'b0);
    add_vector(div_pkg::op_rem, to_word(-7), to_word(-2), to_word(-1), 1'b0);
    add_vector(div_pkg::op_div, to_word(7), to_word(2), to_word(3), 1'b0);
    add_vector(div_pkg::op_rem, to_word(7), to_word(2), to_word(1), 1'b0);
    add_vector(div_pkg::op_div, to_word(5), '0, '1, 1'b0);
    add_vector(div_pkg::op_divu, to_word(5), '0, '1, 1'b0);
    add_vector(div_pkg::op_rem, to_word(5), '0, to_word(5), 1'b0);
    add_vector(div_pkg::op_remu, to_word(5), '0, to_word(5), 1'b0);
    add_vector(div_pkg::op_div, to_word(-5), '0, '1, 1'b0);
    add_vector(div_pkg::op_rem, to_word(-5), '0, to_word(-5), 1'b0);
    add_vector(div_pkg::op_div, min_int, '1, min_int, 1'b0);
    add_vector(div_pkg::op_rem, min_int, '1, '0, 1'b0);
    add_vector(div_pkg::op_divu, min_int, '1, '0, 1'b0);
    add_vector(div_pkg::op_remu, min_int, '1, min_int, 1'b0);
    add_vector(div_pkg::op_div, min_int, to_word(2), min_int | (min_int >> 1), 1'b0);
    add_vector(div_pkg::op_rem, min_int, to_word(3), to_word(-2), 1'b0);
    add_vector(div_pkg::op_remu, to_word(1000), to_word(7), to_word(6), 1'b0);
  endtask

  task automatic run_test(input logic [1:0] t_op, input logic [width-1:0] a,
                          input logic [width-1:0] b, input logic [width-1:0] expected,
                          input logic poke);
    int cycles;
    int extra;
    int errs_before;
    int exp_lat;
    logic done;
    errs_before = errors;
    exp_lat     = expected_latency(t_op, a, b);
    cycles      = 0;
    done        = 1'b0;
    while (busy) @(negedge clk);
    @(posedge clk);
    enable <= 1'b1;
    op     <= t_op;
    rdata1 <= a;
    rdata2 <= b;
    while (!done) begin
      @(posedge clk);
      if (poke && (cycles == 2)) begin
        enable <= 1'b1; // Must be dropped since an operation is in flight
        op     <= div_pkg::op_divu;
        rdata1 <= to_word(10);
        rdata2 <= to_word(2);
      end else begin
        enable <= 1'b0;
      end
      @(negedge clk);
      if (ready) begin
        done = 1'b1;
      end else begin
        cycles++; // Edges from the one that samples enable up to the one that raises ready
      end
      if (poke && (cycles == 3)) begin
        check("busy during second enable", busy, 1);
      end
    end
    check("result", result, expected);
    check("latency", cycles, exp_lat);
    if (poke) begin
      extra = 0;
      repeat (width + 4) begin
        @(negedge clk);
        if (ready || busy) begin
          extra++;
        end
      end
      check("ready or busy after completion", extra, 0);
    end
    tests_run++;
    $display("test %0d op %0d a %h b %h result %h cycles %0d %s", tests_run, t_op, a, b,
             result, cycles, (errors == errs_before) ? "ok" : "wrong");
  endtask

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= timeout_limit) begin
      $display("Timeout after %0d cycles before all tests finished", cycle_count);
      $display("SIMULATION FAILED");
      $finish;
    end
  end

  initial begin
    logic [1:0]       r_op;
    logic [width-1:0] r_a;
    logic [width-1:0] r_b;
    enable     = 1'b0;
    op         = '0;
    rdata1     = '0;
    rdata2     = '0;
    lfsr_state = 16'd22192;
    load_table();
    wait (rst === 1'b1);
    @(negedge clk);
    check("ready after reset", ready, 0);
    check("busy after reset", busy, 0);
    check("result after reset", result, 0);
    tests_run++;
    $display("test %0d reset state ready %b busy %b result %h", tests_run, ready, busy, result);
    for (int i = 0; i < n_table; i++) begin
      run_test(tab_op[i], tab_a[i], tab_b[i], tab_exp[i], tab_poke[i]);
    end
    for (int i = 0; i < n_random; i++) begin
      for (int j = 0; j < width; j++) begin
        r_a[j] = take_bit();
      end
      for (int j = 0; j < width; j++) begin
        r_b[j] = take_bit();
      end
      r_op[1] = take_bit();
      r_op[0] = take_bit();
      run_test(r_op, r_a, r_b, model_result(r_op, r_a, r_b), 1'b0);
    end
    $display("tests run %0d failed checks %0d", tests_run, errors);
    if (errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

// ==== verification/div_tb_clock.sv ====
`timescale 1ns/10ps

module div_tb_clock #(
  parameter int half_period  = 20,
  parameter int reset_cycles = 4
) (
  output logic clk,
  output logic rst
);

  initial begin
    clk = 1'b0;
    forever #half_period clk = ~clk; // 40 ns period
  end

  initial begin
    rst = 1'b0;
    repeat (reset_cycles) @(posedge clk);
    rst <= 1'b1; // Released on a rising edge like every other input
  end

endmodule
